// File: src/ex_defs.svh
// execute stage width parameters and mmio address window
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// data path width
`define EX_XLEN 32

// register file index width
`define EX_REG_AW 5

// peripheral window at 0x8000_0000, 256 bytes
`define EX_MMIO_BASE 32'h8000_0000
`define EX_MMIO_MASK 32'hFFFF_FF00

`endif

// File: src/rv_isa_pkg.sv
// RV32I word, register index, funct3 and ALU operation types
`default_nettype none
`include "ex_defs.svh"

package rv_isa_pkg;

    typedef logic [`EX_XLEN-1:0]   word_t;
    typedef logic [`EX_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [3:0]            byte_en_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } alu_op_e;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // store sizes
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // csr source, register or zimm
    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRWI = 3'b101;

endpackage

`default_nettype wire

// File: src/ex_ctrl_pkg.sv
// pipeline control enums: write-back select, operand sources and jump kind
`default_nettype none

package ex_ctrl_pkg;

    // write-back data source
    typedef enum logic [1:0] {
        WB_ALU      = 2'b00,
        WB_PC_PLUS4 = 2'b01,
        WB_LOAD     = 2'b10
    } wb_sel_e;

    // alu operand a
    typedef enum logic {
        SRC_A_REG = 1'b0,
        SRC_A_PC  = 1'b1
    } src_a_e;

    // alu operand b
    typedef enum logic {
        SRC_B_REG = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

    typedef enum logic [1:0] {
        JUMP_NONE = 2'b00,
        JUMP_JAL  = 2'b01,
        JUMP_JALR = 2'b10
    } jump_e;

endpackage

`default_nettype wire

// File: src/ex_mem_if.sv
// execute results bundle handed from the execute stage to the EX/MEM register
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_if
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
();

    logic      valid;
    word_t     addr;
    word_t     wdata;
    byte_en_t  be;
    reg_addr_t rd_addr;
    wb_sel_e   wb_sel;
    logic      wb_en;
    word_t     wb_data;
    logic      csr_we;
    word_t     csr_data;
    logic      mmio;

    modport producer (
        output valid, addr, wdata, be, rd_addr, wb_sel, wb_en, wb_data,
        output csr_we, csr_data, mmio
    );

    modport consumer (
        input valid, addr, wdata, be, rd_addr, wb_sel, wb_en, wb_data,
        input csr_we, csr_data, mmio
    );

endinterface

`default_nettype wire

// File: src/ex_forward.sv
// forwarding unit and operand muxes for ALU, branch compare and store data
`timescale 1ns/1ps
`default_nettype none

module ex_forward
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
(
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     pc_i,
    input  word_t     imm_i,
    input  word_t     fwd_data_i,
    input  logic      fwd_en_i,
    input  reg_addr_t fwd_addr_i,
    input  src_a_e    src_a_i,
    input  src_b_e    src_b_i,
    output word_t     alu_a_o,
    output word_t     alu_b_o,
    output word_t     cmp_a_o,
    output word_t     cmp_b_o,
    output word_t     store_data_o
);

    word_t rs1_val;
    word_t rs2_val;

    // x0 is hardwired, never take the bypass for it
    function automatic word_t bypass(
        input reg_addr_t addr,
        input word_t     data,
        input logic      en,
        input reg_addr_t src_addr,
        input word_t     src_data
    );
        if (en && (addr != '0) && (addr == src_addr)) begin
            return src_data;
        end
        return data;
    endfunction

    assign rs1_val = bypass(rs1_addr_i, rs1_data_i, fwd_en_i, fwd_addr_i, fwd_data_i);
    assign rs2_val = bypass(rs2_addr_i, rs2_data_i, fwd_en_i, fwd_addr_i, fwd_data_i);

    assign alu_a_o = (src_a_i == SRC_A_PC)  ? pc_i  : rs1_val;
    assign alu_b_o = (src_b_i == SRC_B_IMM) ? imm_i : rs2_val;

    // compare and store always see the register values
    assign cmp_a_o      = rs1_val;
    assign cmp_b_o      = rs2_val;
    assign store_data_o = rs2_val;

endmodule

`default_nettype wire

// File: src/ex_alu.sv
// ALU, load/store address adder and branch comparator with redirect target
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_alu
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
(
    input  word_t   alu_a_i,
    input  word_t   alu_b_i,
    input  word_t   cmp_a_i,
    input  word_t   cmp_b_i,
    input  word_t   pc_i,
    input  word_t   imm_i,
    input  alu_op_e alu_op_i,
    input  funct3_t funct3_i,
    input  logic    branch_i,
    input  jump_e   jump_i,
    output word_t   result_o,
    output word_t   addr_o,
    output word_t   target_o,
    output logic    taken_o
);

    logic [4:0] shamt;
    logic       cond;
    word_t      jalr_sum;

    assign shamt = alu_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   result_o = alu_a_i + alu_b_i;
            ALU_SUB:   result_o = alu_a_i - alu_b_i;
            ALU_SLL:   result_o = alu_a_i << shamt;
            ALU_SLT:   result_o = word_t'($signed(alu_a_i) < $signed(alu_b_i));
            ALU_SLTU:  result_o = word_t'(alu_a_i < alu_b_i);
            ALU_XOR:   result_o = alu_a_i ^ alu_b_i;
            ALU_SRL:   result_o = alu_a_i >> shamt;
            ALU_SRA:   result_o = word_t'($signed(alu_a_i) >>> shamt);
            ALU_OR:    result_o = alu_a_i | alu_b_i;
            ALU_AND:   result_o = alu_a_i & alu_b_i;
            // lui path
            ALU_PASSB: result_o = alu_b_i;
            default:   result_o = '0;
        endcase
    end

    // load/store effective address
    assign addr_o = alu_a_i + imm_i;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = (cmp_a_i == cmp_b_i);
            F3_BNE:  cond = (cmp_a_i != cmp_b_i);
            F3_BLT:  cond = ($signed(cmp_a_i) < $signed(cmp_b_i));
            F3_BGE:  cond = ($signed(cmp_a_i) >= $signed(cmp_b_i));
            F3_BLTU: cond = (cmp_a_i < cmp_b_i);
            F3_BGEU: cond = (cmp_a_i >= cmp_b_i);
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = branch_i && cond;

    // jalr clears bit 0 of the sum
    assign jalr_sum = cmp_a_i + imm_i;
    assign target_o = (jump_i == JUMP_JALR) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc_i + imm_i;

endmodule

`default_nettype wire

// File: src/ex_store_align.sv
// store byte enables and lane replication for byte, half and word stores
`timescale 1ns/1ps
`default_nettype none

module ex_store_align
    import rv_isa_pkg::*;
(
    input  logic [1:0] addr_lsb_i,
    input  funct3_t    funct3_i,
    input  logic       store_i,
    input  word_t      data_i,
    output byte_en_t   be_o,
    output word_t      wdata_o
);

    byte_en_t be;

    always_comb begin
        case (funct3_i)
            F3_SB: begin
                be      = byte_en_t'(4'b0001 << addr_lsb_i);
                wdata_o = {4{data_i[7:0]}};
            end
            F3_SH: begin
                // upper or lower half, offset bit 0 ignored
                be      = addr_lsb_i[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{data_i[15:0]}};
            end
            F3_SW: begin
                be      = 4'b1111;
                wdata_o = data_i;
            end
            default: begin
                be      = 4'b0000;
                wdata_o = data_i;
            end
        endcase
    end

    assign be_o = store_i ? be : '0;

endmodule

`default_nettype wire

// File: src/ex_stage.sv
// execute stage: forwarding, ALU, store alignment, write-back/CSR data and mmio decode
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_stage
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
(
    input  logic      valid_i,
    input  word_t     pc_i,
    input  word_t     pc_plus4_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     imm_i,
    input  alu_op_e   alu_op_i,
    input  funct3_t   funct3_i,
    input  src_a_e    src_a_i,
    input  src_b_e    src_b_i,
    input  wb_sel_e   wb_sel_i,
    input  logic      wb_en_i,
    input  logic      store_i,
    input  logic      branch_i,
    input  jump_e     jump_i,
    input  logic      csr_we_i,
    input  logic      fwd_en_i,
    input  reg_addr_t fwd_addr_i,
    input  word_t     fwd_data_i,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    ex_mem_if.producer ex_o
);

    word_t alu_a;
    word_t alu_b;
    word_t cmp_a;
    word_t cmp_b;
    word_t store_data;
    word_t alu_result;
    word_t addr;
    logic  taken;
    logic  in_window;

    ex_forward u_ex_forward (
        .rs1_addr_i   (rs1_addr_i),
        .rs2_addr_i   (rs2_addr_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .fwd_data_i   (fwd_data_i),
        .fwd_en_i     (fwd_en_i),
        .fwd_addr_i   (fwd_addr_i),
        .src_a_i      (src_a_i),
        .src_b_i      (src_b_i),
        .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),
        .cmp_a_o      (cmp_a),
        .cmp_b_o      (cmp_b),
        .store_data_o (store_data)
    );

    ex_alu u_ex_alu (
        .alu_a_i  (alu_a),
        .alu_b_i  (alu_b),
        .cmp_a_i  (cmp_a),
        .cmp_b_i  (cmp_b),
        .pc_i     (pc_i),
        .imm_i    (imm_i),
        .alu_op_i (alu_op_i),
        .funct3_i (funct3_i),
        .branch_i (branch_i),
        .jump_i   (jump_i),
        .result_o (alu_result),
        .addr_o   (addr),
        .target_o (redirect_pc_o),
        .taken_o  (taken)
    );

    ex_store_align u_ex_store_align (
        .addr_lsb_i (addr[1:0]),
        .funct3_i   (funct3_i),
        .store_i    (store_i),
        .data_i     (store_data),
        .be_o       (ex_o.be),
        .wdata_o    (ex_o.wdata)
    );

    assign redirect_o = valid_i && (taken || (jump_i != JUMP_NONE));

    // peripheral window, loads and stores only
    assign in_window = ((addr & `EX_MMIO_MASK) == `EX_MMIO_BASE);
    assign ex_o.mmio = in_window && (store_i || (wb_sel_i == WB_LOAD));

    assign ex_o.valid   = valid_i;
    assign ex_o.addr    = addr;
    assign ex_o.rd_addr = rd_addr_i;
    assign ex_o.wb_sel  = wb_sel_i;
    assign ex_o.wb_en   = wb_en_i;
    assign ex_o.wb_data = (wb_sel_i == WB_PC_PLUS4) ? pc_plus4_i : alu_result;
    assign ex_o.csr_we  = csr_we_i;

    // csrrw takes rs1, csrrwi takes the zimm
    assign ex_o.csr_data = (funct3_i == F3_CSRRW)  ? cmp_a :
                           (funct3_i == F3_CSRRWI) ? imm_i : '0;

endmodule

`default_nettype wire

// File: src/ex_mem_reg.sv
// EX/MEM pipeline register with stall hold and flush clear
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      stall_i,
    input  logic      flush_i,
    ex_mem_if.consumer ex_i,
    output logic      mem_valid_o,
    output word_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output byte_en_t  mem_be_o,
    output reg_addr_t mem_rd_addr_o,
    output wb_sel_e   mem_wb_sel_o,
    output logic      mem_wb_en_o,
    output word_t     mem_wb_data_o,
    output logic      mem_csr_we_o,
    output word_t     mem_csr_data_o,
    output logic      mem_mmio_o,
    output logic      mem_is_load_o
);

    // enables, flush beats stall
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            mem_valid_o  <= 1'b0;
            mem_wb_en_o  <= 1'b0;
            mem_csr_we_o <= 1'b0;
            mem_be_o     <= '0;
            mem_mmio_o   <= 1'b0;
        end else if (!stall_i) begin
            mem_valid_o  <= ex_i.valid;
            mem_wb_en_o  <= ex_i.valid && ex_i.wb_en;
            mem_csr_we_o <= ex_i.valid && ex_i.csr_we;
            mem_be_o     <= ex_i.valid ? ex_i.be : '0;
            mem_mmio_o   <= ex_i.valid && ex_i.mmio;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            mem_addr_o     <= ex_i.addr;
            mem_wdata_o    <= ex_i.wdata;
            mem_rd_addr_o  <= ex_i.rd_addr;
            mem_wb_sel_o   <= ex_i.wb_sel;
            mem_wb_data_o  <= ex_i.wb_data;
            mem_csr_data_o <= ex_i.csr_data;
        end
    end

    assign mem_is_load_o = (mem_wb_sel_o == WB_LOAD);

endmodule

`default_nettype wire

// File: src/ex_unit_top.sv
// execute unit top: execute stage plus EX/MEM register on plain ports
`timescale 1ns/1ps
`default_nettype none

module ex_unit_top
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  word_t     pc_i,
    input  word_t     pc_plus4_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     imm_i,
    input  alu_op_e   alu_op_i,
    input  funct3_t   funct3_i,
    input  src_a_e    src_a_i,
    input  src_b_e    src_b_i,
    input  wb_sel_e   wb_sel_i,
    input  logic      wb_en_i,
    input  logic      store_i,
    input  logic      branch_i,
    input  jump_e     jump_i,
    input  logic      csr_we_i,
    input  logic      fwd_en_i,
    input  reg_addr_t fwd_addr_i,
    input  word_t     fwd_data_i,
    input  logic      stall_i,
    input  logic      flush_i,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    output logic      mem_valid_o,
    output word_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output byte_en_t  mem_be_o,
    output reg_addr_t mem_rd_addr_o,
    output wb_sel_e   mem_wb_sel_o,
    output logic      mem_wb_en_o,
    output word_t     mem_wb_data_o,
    output logic      mem_csr_we_o,
    output word_t     mem_csr_data_o,
    output logic      mem_mmio_o,
    output logic      mem_is_load_o
);

    ex_mem_if u_ex_mem_if ();

    ex_stage u_ex_stage (
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .pc_plus4_i    (pc_plus4_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rd_addr_i     (rd_addr_i),
        .imm_i         (imm_i),
        .alu_op_i      (alu_op_i),
        .funct3_i      (funct3_i),
        .src_a_i       (src_a_i),
        .src_b_i       (src_b_i),
        .wb_sel_i      (wb_sel_i),
        .wb_en_i       (wb_en_i),
        .store_i       (store_i),
        .branch_i      (branch_i),
        .jump_i        (jump_i),
        .csr_we_i      (csr_we_i),
        .fwd_en_i      (fwd_en_i),
        .fwd_addr_i    (fwd_addr_i),
        .fwd_data_i    (fwd_data_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .ex_o          (u_ex_mem_if.producer)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .ex_i           (u_ex_mem_if.consumer),
        .mem_valid_o    (mem_valid_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_be_o       (mem_be_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_wb_sel_o   (mem_wb_sel_o),
        .mem_wb_en_o    (mem_wb_en_o),
        .mem_wb_data_o  (mem_wb_data_o),
        .mem_csr_we_o   (mem_csr_we_o),
        .mem_csr_data_o (mem_csr_data_o),
        .mem_mmio_o     (mem_mmio_o),
        .mem_is_load_o  (mem_is_load_o)
    );

endmodule

`default_nettype wire

// File: tb/ex_unit_chk.sv
// concurrent assertions on the EX/MEM register: clear after reset or flush, stall hold, be gating
`timescale 1ns/1ps
`default_nettype none

module ex_unit_chk
    import rv_isa_pkg::*;
(
    input logic     clk_i,
    input logic     reset_i,
    input logic     stall_i,
    input logic     flush_i,
    input logic     valid_i,
    input logic     wb_en_i,
    input logic     csr_we_i,
    input logic     mmio_i,
    input byte_en_t be_i,
    input word_t    addr_i,
    input word_t    wdata_i,
    input word_t    wb_data_i,
    input word_t    csr_data_i
);

    int fail_count = 0;

    a_clear: assert property (@(posedge clk_i) (reset_i || flush_i) |=>
        (!valid_i && !wb_en_i && !csr_we_i && !mmio_i && (be_i == 4'b0000)))
        else begin
            $error("enables not cleared after reset or flush");
            fail_count++;
        end

    // flush and reset win over stall
    a_stall_hold: assert property (@(posedge clk_i) (stall_i && !flush_i && !reset_i) |=>
        ($stable(valid_i) && $stable(wb_en_i) && $stable(csr_we_i) && $stable(mmio_i)
         && $stable(be_i) && $stable(addr_i) && $stable(wdata_i)
         && $stable(wb_data_i) && $stable(csr_data_i)))
        else begin
            $error("registered outputs changed during stall");
            fail_count++;
        end

    a_be_gated: assert property (@(posedge clk_i) disable iff (reset_i)
        !valid_i |-> (be_i == 4'b0000))
        else begin
            $error("byte enables set on an invalid stage");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tb/tb_ex_unit.sv
// execute unit testbench with xorshift stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module tb_ex_unit
    import rv_isa_pkg::*, ex_ctrl_pkg::*;
();

    localparam int CLK_NS          = 100;
    localparam int NUM_INSTR       = 2000;
    localparam int WATCHDOG_CYCLES = NUM_INSTR + 100;

    logic      clk_i;
    logic      reset_i;
    logic      valid_i;
    word_t     pc_i;
    word_t     pc_plus4_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_addr_i;
    reg_addr_t rs2_addr_i;
    reg_addr_t rd_addr_i;
    word_t     imm_i;
    alu_op_e   alu_op_i;
    funct3_t   funct3_i;
    src_a_e    src_a_i;
    src_b_e    src_b_i;
    wb_sel_e   wb_sel_i;
    logic      wb_en_i;
    logic      store_i;
    logic      branch_i;
    jump_e     jump_i;
    logic      csr_we_i;
    logic      fwd_en_i;
    reg_addr_t fwd_addr_i;
    word_t     fwd_data_i;
    logic      stall_i;
    logic      flush_i;
    logic      redirect_o;
    word_t     redirect_pc_o;
    logic      mem_valid_o;
    word_t     mem_addr_o;
    word_t     mem_wdata_o;
    byte_en_t  mem_be_o;
    reg_addr_t mem_rd_addr_o;
    wb_sel_e   mem_wb_sel_o;
    logic      mem_wb_en_o;
    word_t     mem_wb_data_o;
    logic      mem_csr_we_o;
    word_t     mem_csr_data_o;
    logic      mem_mmio_o;
    logic      mem_is_load_o;

    // model of the current cycle
    word_t    m_rs1;
    word_t    m_rs2;
    word_t    m_alu_a;
    word_t    m_alu_b;
    word_t    m_addr;
    word_t    m_wdata;
    word_t    m_wb_data;
    word_t    m_csr_data;
    word_t    m_target;
    byte_en_t m_be;
    logic     m_mmio;
    logic     m_redirect;

    // expected EX/MEM contents
    logic      e_valid;
    logic      e_wb_en;
    logic      e_csr_we;
    logic      e_mmio;
    byte_en_t  e_be;
    word_t     e_addr;
    word_t     e_wdata;
    word_t     e_wb_data;
    word_t     e_csr_data;
    reg_addr_t e_rd;
    wb_sel_e   e_wb_sel;

    logic [31:0] rng_state = 32'd57;
    logic        checking  = 1'b0;
    int          n_checks  = 0;
    int          n_errors  = 0;
    int          assert_fails;

    ex_unit_top u_ex_unit_top (.*);

    bind ex_mem_reg ex_unit_chk u_ex_unit_chk (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .valid_i    (mem_valid_o),
        .wb_en_i    (mem_wb_en_o),
        .csr_we_i   (mem_csr_we_o),
        .mmio_i     (mem_mmio_o),
        .be_i       (mem_be_o),
        .addr_i     (mem_addr_o),
        .wdata_i    (mem_wdata_o),
        .wb_data_i  (mem_wb_data_o),
        .csr_data_i (mem_csr_data_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t forwarded(input reg_addr_t addr, input word_t data);
        if (fwd_en_i && (addr != 5'd0) && (addr == fwd_addr_i)) begin
            return fwd_data_i;
        end
        return data;
    endfunction

    // signed compare by sign bits first
    function automatic logic signed_less(input word_t a, input word_t b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a + ~b + 32'd1;
            ALU_SLL:   return a << sh;
            ALU_SLT:   return {31'h0, signed_less(a, b)};
            ALU_SLTU:  return {31'h0, a < b};
            ALU_XOR:   return a ^ b;
            ALU_SRL:   return a >> sh;
            ALU_SRA:   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            ALU_OR:    return a | b;
            ALU_AND:   return a & b;
            ALU_PASSB: return b;
            default:   return 32'h0;
        endcase
    endfunction

    function automatic logic branch_cond(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return signed_less(a, b);
            3'b101:  return !signed_less(a, b);
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic compute_expected();
        word_t jalr_sum;
        m_rs1     = forwarded(rs1_addr_i, rs1_data_i);
        m_rs2     = forwarded(rs2_addr_i, rs2_data_i);
        m_alu_a   = (src_a_i == SRC_A_PC) ? pc_i : m_rs1;
        m_alu_b   = (src_b_i == SRC_B_IMM) ? imm_i : m_rs2;
        m_addr    = m_alu_a + imm_i;
        m_wb_data = (wb_sel_i == WB_PC_PLUS4) ? pc_plus4_i : alu_model(alu_op_i, m_alu_a, m_alu_b);
        case (funct3_i)
            3'b000: begin
                m_be    = 4'b0001 << m_addr[1:0];
                m_wdata = {4{m_rs2[7:0]}};
            end
            3'b001: begin
                m_be    = m_addr[1] ? 4'b1100 : 4'b0011;
                m_wdata = {2{m_rs2[15:0]}};
            end
            3'b010: begin
                m_be    = 4'b1111;
                m_wdata = m_rs2;
            end
            default: begin
                m_be    = 4'b0000;
                m_wdata = m_rs2;
            end
        endcase
        if (!store_i) begin
            m_be = 4'b0000;
        end
        m_mmio = ((m_addr & `EX_MMIO_MASK) == `EX_MMIO_BASE) && (store_i || wb_sel_i == WB_LOAD);
        case (funct3_i)
            3'b001:  m_csr_data = m_rs1;
            3'b101:  m_csr_data = imm_i;
            default: m_csr_data = 32'h0;
        endcase
        m_redirect = valid_i && ((branch_i && branch_cond(funct3_i, m_rs1, m_rs2))
                                 || (jump_i != JUMP_NONE));
        jalr_sum   = m_rs1 + imm_i;
        m_target   = (jump_i == JUMP_JALR) ? (jalr_sum & ~32'd1) : (pc_i + imm_i);
    endtask

    // one clock edge of the EX/MEM register fed by the model of the previous negedge
    task automatic update_expected_reg();
        if (reset_i || flush_i) begin
            e_valid  = 1'b0;
            e_wb_en  = 1'b0;
            e_csr_we = 1'b0;
            e_be     = 4'b0000;
            e_mmio   = 1'b0;
        end else if (!stall_i) begin
            e_valid  = valid_i;
            e_wb_en  = valid_i && wb_en_i;
            e_csr_we = valid_i && csr_we_i;
            e_be     = valid_i ? m_be : 4'b0000;
            e_mmio   = valid_i && m_mmio;
        end
        if (!stall_i) begin
            e_addr     = m_addr;
            e_wdata    = m_wdata;
            e_wb_data  = m_wb_data;
            e_csr_data = m_csr_data;
            e_rd       = rd_addr_i;
            e_wb_sel   = wb_sel_i;
        end
    endtask

    task automatic drive_random();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        r0 = rand_word();
        r1 = rand_word();
        r2 = rand_word();
        r3 = rand_word();
        r4 = rand_word();
        r5 = rand_word();
        valid_i    <= r0[2:0] != 3'd0;
        rs1_addr_i <= {3'b000, r0[4:3]};
        rs2_addr_i <= {3'b000, r0[6:5]};
        rd_addr_i  <= r0[11:7];
        fwd_addr_i <= {3'b000, r0[13:12]};
        fwd_en_i   <= r0[14];
        alu_op_i   <= alu_op_e'(r0[18:15] % 4'd11);
        funct3_i   <= r0[21:19];
        src_a_i    <= src_a_e'(r0[22]);
        src_b_i    <= src_b_e'(r0[23]);
        wb_sel_i   <= wb_sel_e'((r0[25:24] == 2'd3) ? 2'd0 : r0[25:24]);
        wb_en_i    <= r0[26];
        store_i    <= r0[27];
        branch_i   <= r0[28];
        jump_i     <= jump_e'((r0[30:29] == 2'd3) ? 2'd0 : r0[30:29]);
        csr_we_i   <= r0[31];
        pc_i       <= {r1[31:2], 2'b00};
        pc_plus4_i <= {r1[31:2], 2'b00} + 32'd4;
        rs2_data_i <= r3;
        fwd_data_i <= r5;
        stall_i    <= r4[15:13] == 3'd0;
        flush_i    <= r4[19:16] == 4'd0;
        // steer some addresses into and just past the mmio window
        if (r1[1:0] == 2'd0) begin
            rs1_data_i <= `EX_MMIO_BASE | {24'h0, r2[7:0]};
            imm_i      <= {24'h0, r4[7:0]};
        end else begin
            rs1_data_i <= r2;
            imm_i      <= r4[12] ? r5 : {{20{r4[11]}}, r4[11:0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    // redirect is combinational and the rest comes from the register
    always @(negedge clk_i) begin
        compute_expected();
        if (checking) begin
            check_value("redirect_o", {31'h0, redirect_o}, {31'h0, m_redirect});
            check_value("redirect_pc_o", redirect_pc_o, m_target);
            check_value("mem_valid_o", {31'h0, mem_valid_o}, {31'h0, e_valid});
            check_value("mem_wb_en_o", {31'h0, mem_wb_en_o}, {31'h0, e_wb_en});
            check_value("mem_csr_we_o", {31'h0, mem_csr_we_o}, {31'h0, e_csr_we});
            check_value("mem_be_o", {28'h0, mem_be_o}, {28'h0, e_be});
            check_value("mem_mmio_o", {31'h0, mem_mmio_o}, {31'h0, e_mmio});
            check_value("mem_addr_o", mem_addr_o, e_addr);
            check_value("mem_wdata_o", mem_wdata_o, e_wdata);
            check_value("mem_wb_data_o", mem_wb_data_o, e_wb_data);
            check_value("mem_csr_data_o", mem_csr_data_o, e_csr_data);
            check_value("mem_rd_addr_o", {27'h0, mem_rd_addr_o}, {27'h0, e_rd});
            check_value("mem_wb_sel_o", {30'h0, mem_wb_sel_o}, {30'h0, e_wb_sel});
            check_value("mem_is_load_o", {31'h0, mem_is_load_o},
                        {31'h0, e_wb_sel == WB_LOAD});
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset_i    = 1'b1;
        // a live mmio word store with write-back and csr write sits on the inputs during reset
        valid_i    = 1'b1;
        pc_i       = '0;
        pc_plus4_i = '0;
        rs1_data_i = `EX_MMIO_BASE;
        rs2_data_i = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        rd_addr_i  = '0;
        imm_i      = '0;
        alu_op_i   = ALU_ADD;
        funct3_i   = 3'b010;
        src_a_i    = SRC_A_REG;
        src_b_i    = SRC_B_REG;
        wb_sel_i   = WB_ALU;
        wb_en_i    = 1'b1;
        store_i    = 1'b1;
        branch_i   = 1'b0;
        jump_i     = JUMP_NONE;
        csr_we_i   = 1'b1;
        fwd_en_i   = 1'b0;
        fwd_addr_i = '0;
        fwd_data_i = '0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        repeat (10) begin
            @(posedge clk_i);
            update_expected_reg();
        end
        reset_i  <= 1'b0;
        checking = 1'b1;
        repeat (NUM_INSTR) begin
            @(posedge clk_i);
            update_expected_reg();
            drive_random();
        end
        valid_i <= 1'b0;
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        repeat (2) begin
            @(posedge clk_i);
            update_expected_reg();
        end
        // past the last negedge compare
        @(negedge clk_i);
        #(CLK_NS / 4);
        checking     = 1'b0;
        assert_fails = u_ex_unit_top.u_ex_mem_reg.u_ex_unit_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, assert_fails);
        if ((n_errors == 0) && (assert_fails == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/rv_isa_pkg.sv
src/ex_ctrl_pkg.sv
src/ex_mem_if.sv
src/ex_forward.sv
src/ex_alu.sv
src/ex_store_align.sv
src/ex_stage.sv
src/ex_mem_reg.sv
src/ex_unit_top.sv
tb/ex_unit_chk.sv
tb/tb_ex_unit.sv

// File: Makefile
# Verilator build, run, lint and clean for the execute unit testbench
VERILATOR ?= verilator
TOP       ?= tb_ex_unit
RTL_TOP   ?= ex_unit_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
LINT_FLAGS ?=
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

RTL_SRCS  := $(filter src/%,$(shell grep -v '^+' $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qx "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+src $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
